// File: source/sadPkg.sv
package sadPkg;

	localparam int pixelWidth = 8;    // bits per pixel
	localparam int prefixSpeed = 1;   // 0 serial, 1 brent-kung, 2 sklansky
	localparam int fifoDepth = 4;     // power of two
	localparam int fifoAddrWidth = $clog2(fifoDepth);
	localparam int sadWidth = 16;     // accumulator width
	localparam int countWidth = 8;    // match counter width

	typedef logic [pixelWidth-1:0] pixelT;        // pixel or abs difference
	typedef logic [sadWidth-1:0] sadT;            // block sad
	typedef logic [countWidth-1:0] countT;        // matching pixels per block
	typedef logic [fifoAddrWidth-1:0] fifoAddrT;  // fifo pointer

	// one difference on its way from producer to consumer
	typedef struct packed {
		pixelT absDiff;
		logic isMatch;  // pair was equal
		logic isLast;   // final pair of block
	} diffItemT;

	// block result
	typedef struct packed {
		sadT sad;
		countT matchCount;
	} sadResultT;

endpackage

// File: source/prefixAndOr.sv
`timescale 1ns/1ps

module prefixAndOr #(
	parameter int width = 8,  // word width
	parameter int speed = 1   // 0 serial, 1 brent-kung, 2 sklansky
) (
	input logic [width-1:0] GI,   // generate in
	input logic [width-1:0] PI,   // propagate in
	output logic [width-1:0] GO,  // prefix generate out
	output logic [width-1:0] PO   // prefix propagate out
);

	localparam int m = $clog2(width);  // tree depth

	if (speed == 2) begin : gSklansky
		logic [width-1:0] gT [0:m];  // per-level generate
		logic [width-1:0] pT [0:m];  // per-level propagate
		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : gLevel
			localparam int half = 2**(l-1);  // block size merged at this level
			for (genvar i = 0; i < width; i++) begin : gBit
				// upper half of each block takes the top of the lower half
				if ((i / half) % 2 == 1) begin : gNode
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][(i/half)*half - 1]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][(i/half)*half - 1];
				end else begin : gPass
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end
		assign GO = gT[m];
		assign PO = pT[m];
	end else if (speed == 1) begin : gBrentKung
		localparam int lastLevel = (m > 0) ? 2*m - 1 : 0;
		logic [width-1:0] gT [0:lastLevel];
		logic [width-1:0] pT [0:lastLevel];
		assign gT[0] = GI;
		assign pT[0] = PI;
		// up-sweep, span doubles each level
		for (genvar l = 1; l <= m; l++) begin : gUp
			localparam int span = 2**l;
			for (genvar i = 0; i < width; i++) begin : gBit
				if ((i + 1) % span == 0) begin : gNode
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][i - span/2]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][i - span/2];
				end else begin : gPass
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end
		// down-sweep fills the bits between the tree roots
		for (genvar l = m + 1; l <= lastLevel; l++) begin : gDown
			localparam int span = 2**(2*m - l);
			for (genvar i = 0; i < width; i++) begin : gBit
				if (((i + 1) % span == span/2) && (i + 1 > span)) begin : gNode
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][i - span/2]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][i - span/2];
				end else begin : gPass
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end
		assign GO = gT[lastLevel];
		assign PO = pT[lastLevel];
	end else begin : gSerial
		// ripple chain, one node per bit
		assign GO[0] = GI[0];
		assign PO[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : gBit
			assign GO[i] = GI[i] | (PI[i] & GO[i-1]);
			assign PO[i] = PI[i] & PO[i-1];
		end
	end

endmodule

// File: source/subCZ.sv
`timescale 1ns/1ps

// {CO,S} = A - B - CI, Z = (S == 0) valid for CI = 0 only
module subCZ #(
	parameter int width = 8,  // word width
	parameter int speed = 1   // prefix structure
) (
	input logic [width-1:0] A,   // minuend
	input logic [width-1:0] B,   // subtrahend
	input logic CI,              // borrow in, subtracted
	output logic [width-1:0] S,  // difference
	output logic CO,             // set when result negative
	output logic Z               // zero flag
);

	logic [width-1:0] bInv;      // ~B
	logic ciInv;                 // ~CI acts as carry in
	logic [width-1:0] gIn, pIn;  // pre-processed gen/prop
	logic [width-1:0] gOut, pOut;

	assign bInv = ~B;
	assign ciInv = ~CI;

	// carry in folded into bit 0 as a majority term
	assign gIn[0] = (A[0] & bInv[0]) | (A[0] & ciInv) | (bInv[0] & ciInv);
	assign pIn[0] = A[0] ^ bInv[0];
	for (genvar i = 1; i < width; i++) begin : gPre
		assign gIn[i] = A[i] & bInv[i];
		assign pIn[i] = A[i] ^ bInv[i];
	end

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) i_prefix (
		.GI(gIn),
		.PI(pIn),
		.GO(gOut),
		.PO(pOut)
	);

	assign S = pIn ^ {gOut[width-2:0], ciInv};  // carry into bit i is prefix of i-1
	assign CO = ~gOut[width-1];  // no carry out means borrow
	assign Z = pOut[width-1];    // all bits propagate when A == B

endmodule

// File: source/pixelDiffer.sv
`timescale 1ns/1ps

module pixelDiffer (
	input logic clk,
	input logic reset,
	input logic inStrobe,             // one pulse per pair
	input sadPkg::pixelT pixelA,
	input sadPkg::pixelT pixelB,
	input logic inLast,               // final pair of block
	output logic pushStrobe,
	output sadPkg::diffItemT pushItem
);

	import sadPkg::*;

	pixelT diff;     // a - b, wraps when negative
	pixelT negDiff;  // 0 - diff
	logic borrow;    // a < b
	logic isEqual;

	// first stage gives difference, borrow and zero
	subCZ #(
		.width(pixelWidth),
		.speed(prefixSpeed)
	) i_subDiff (
		.A(pixelA),
		.B(pixelB),
		.CI(1'b0),
		.S(diff),
		.CO(borrow),
		.Z(isEqual)
	);

	// second stage negates for the abs value
	subCZ #(
		.width(pixelWidth),
		.speed(prefixSpeed)
	) i_subNeg (
		.A('0),
		.B(diff),
		.CI(1'b0),
		.S(negDiff),
		.CO(),
		.Z()
	);

	always_ff @(posedge clk) begin
		if (reset) pushStrobe <= 1'b0;
		else pushStrobe <= inStrobe;  // push one cycle after sampling
	end

	always_ff @(posedge clk) begin
		if (inStrobe) begin
			pushItem.absDiff <= borrow ? negDiff : diff;
			pushItem.isMatch <= isEqual;
			pushItem.isLast <= inLast;
		end
	end

endmodule

// File: source/diffFifo.sv
`timescale 1ns/1ps

module diffFifo (
	input logic clk,
	input logic reset,
	input logic pushStrobe,
	input sadPkg::diffItemT pushItem,
	input logic popStrobe,
	output sadPkg::diffItemT headItem,  // oldest entry
	output logic empty,
	output logic overflow                // sticky until reset
);

	import sadPkg::*;

	diffItemT mem [fifoDepth];
	fifoAddrT wrPtr, rdPtr;
	logic [fifoAddrWidth:0] count;  // occupancy, 0 to fifoDepth
	logic full;
	logic doPush, doPop;

	assign full = (count == fifoDepth);
	assign empty = (count == '0);
	assign headItem = mem[rdPtr];

	assign doPop = popStrobe & ~empty;
	// a pop in the same cycle frees the slot when full
	assign doPush = pushStrobe & (~full | doPop);

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= pushItem;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1;  // wraps at depth
			if (doPop) rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // none or both
			endcase
			if (pushStrobe && !doPush) overflow <= 1'b1;  // item dropped
		end
	end

endmodule

// File: source/sadAccumulator.sv
`timescale 1ns/1ps

module sadAccumulator (
	input logic clk,
	input logic reset,
	input logic hold,                   // stall level
	input logic empty,
	input sadPkg::diffItemT headItem,
	output logic popStrobe,
	output logic sadValid,              // one-cycle pulse
	output sadPkg::sadResultT sadResult
);

	import sadPkg::*;

	sadT sadSum;        // running block sum
	countT matchSum;    // running match count
	sadT sadNext;
	countT matchNext;
	logic [sadWidth:0] sumWide;  // extra bit catches the carry

	assign popStrobe = ~empty & ~hold;

	assign sumWide = {1'b0, sadSum} + {{(sadWidth-pixelWidth+1){1'b0}}, headItem.absDiff};
	assign sadNext = sumWide[sadWidth] ? '1 : sumWide[sadWidth-1:0];  // clamp at top
	assign matchNext = matchSum + countT'(headItem.isMatch);

	always_ff @(posedge clk) begin
		if (reset) begin
			sadSum <= '0;
			matchSum <= '0;
			sadValid <= 1'b0;
		end else begin
			sadValid <= 1'b0;
			if (popStrobe) begin
				if (headItem.isLast) begin
					sadSum <= '0;  // next block starts fresh
					matchSum <= '0;
					sadValid <= 1'b1;
				end else begin
					sadSum <= sadNext;
					matchSum <= matchNext;
				end
			end
		end
	end

	// totals including the last item
	always_ff @(posedge clk) begin
		if (popStrobe && headItem.isLast) begin
			sadResult.sad <= sadNext;
			sadResult.matchCount <= matchNext;
		end
	end

endmodule

// File: source/sadUnit.sv
`timescale 1ns/1ps

module sadUnit (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input sadPkg::pixelT pixelA,
	input sadPkg::pixelT pixelB,
	input logic inLast,
	input logic hold,
	output logic sadValid,
	output sadPkg::sadResultT sadResult,
	output logic overflow
);

	import sadPkg::*;

	logic pushStrobe, popStrobe;
	diffItemT pushItem;
	diffItemT headItem;
	logic empty;

	pixelDiffer i_pixelDiffer (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.pixelA(pixelA),
		.pixelB(pixelB),
		.inLast(inLast),
		.pushStrobe(pushStrobe),
		.pushItem(pushItem)
	);

	diffFifo i_diffFifo (
		.clk(clk),
		.reset(reset),
		.pushStrobe(pushStrobe),
		.pushItem(pushItem),
		.popStrobe(popStrobe),
		.headItem(headItem),
		.empty(empty),
		.overflow(overflow)
	);

	sadAccumulator i_sadAccumulator (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.empty(empty),
		.headItem(headItem),
		.popStrobe(popStrobe),
		.sadValid(sadValid),
		.sadResult(sadResult)
	);

endmodule

// File: bench/sadUnitTb.sv
`timescale 1ns/1ps

module sadUnitTb;

	import sadPkg::*;

	localparam int blockCount = 6;  // random blocks
	localparam int blockLen = 8;    // pairs per random block
	localparam int satLen = 300;    // pairs in the saturating block
	localparam int stimCycles = blockCount*blockLen + 8 + satLen + 4 + 7;
	localparam int cycleLimit = 2*stimCycles + 100;
	localparam int sadMax = 2**sadWidth - 1;

	logic clk = 1'b0;
	logic reset;
	logic inStrobe, inLast, hold;
	pixelT pixelA, pixelB;
	logic sadValid, overflow;
	sadResultT sadResult;

	integer seed;
	int valueErrors = 0;     // wrong block results
	int protocolErrors = 0;  // timing, hold, overflow, reset
	int cycleCount = 0;
	int modelSad, modelMatches;  // running totals of the block being sent
	sadResultT expQ [$];         // expected results in arrival order
	sadResultT expHead;
	logic expPending;
	logic latencyOn;        // fixed latency expected while hold stays low
	logic overflowAllowed;

	// borrow and zero corners of both subtractors
	pixelT dirA [8] = '{8'd37, 8'd0, 8'd255, 8'd100, 8'd101, 8'd0, 8'd255, 8'd128};
	pixelT dirB [8] = '{8'd37, 8'd255, 8'd0, 8'd101, 8'd100, 8'd0, 8'd255, 8'd127};

	sadUnit i_sadUnit (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.pixelA(pixelA),
		.pixelB(pixelB),
		.inLast(inLast),
		.hold(hold),
		.sadValid(sadValid),
		.sadResult(sadResult),
		.overflow(overflow)
	);

	always #2 clk = ~clk;  // 4 ns period

	task automatic refreshHead();
		expPending = (expQ.size() > 0);
		expHead = expPending ? expQ[0] : '0;
	endtask

	// drives one pair for one cycle and updates the model
	task automatic sendPair(input pixelT a, input pixelT b, input logic last);
		int d;
		sadResultT r;
		d = (a > b) ? int'(a) - int'(b) : int'(b) - int'(a);
		modelSad = (modelSad + d > sadMax) ? sadMax : modelSad + d;  // clamp
		if (a == b) modelMatches++;
		if (last) begin
			r.sad = sadT'(modelSad);
			r.matchCount = countT'(modelMatches);
			expQ.push_back(r);
			refreshHead();
			modelSad = 0;
			modelMatches = 0;
		end
		pixelA = a;
		pixelB = b;
		inLast = last;
		inStrobe = 1'b1;
		@(posedge clk);
		#0.5;
		inStrobe = 1'b0;
		inLast = 1'b0;
	endtask

	task automatic sendRandomBlock(input int len);
		pixelT a, b;
		for (int i = 0; i < len; i++) begin
			a = pixelT'($random(seed));
			b = pixelT'($random(seed));
			if (($random(seed) & 3) == 0) b = a;  // some exact matches
			sendPair(a, b, i == len - 1);
		end
	endtask

	task automatic waitDrain();
		while (expPending) begin
			@(posedge clk);
			#0.5;
		end
		@(posedge clk);
		#0.5;
	endtask

	task automatic resetAndCheck();
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#0.5;
		reset = 1'b0;
		hold = 1'b0;
		overflowAllowed = 1'b0;
		modelSad = 0;
		modelMatches = 0;
		expQ.delete();
		refreshHead();
		assert (!sadValid && !overflow) else begin
			protocolErrors++;
			$display("ERR %0t: sadValid or overflow still high after reset", $time);
		end
	endtask

	// retire the expected entry once the dut reports it
	always @(posedge clk) begin
		if (!reset && sadValid && expQ.size() > 0) begin
			void'(expQ.pop_front());
			refreshHead();
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: test did not finish within %0d cycles", cycleLimit);
			$display("Result: FAILED");
			$finish;
		end
	end

	resultCheck: assert property (@(posedge clk) disable iff (reset)
		sadValid |-> (sadResult == expHead))
		else begin
			valueErrors++;
			$display("ERR %0t: sad %0d count %0d, expected sad %0d count %0d", $time,
				$sampled(sadResult.sad), $sampled(sadResult.matchCount),
				$sampled(expHead.sad), $sampled(expHead.matchCount));
		end

	spareCheck: assert property (@(posedge clk) disable iff (reset) sadValid |-> expPending)
		else begin
			protocolErrors++;
			$display("ERR %0t: sadValid with no block outstanding", $time);
		end

	// last pair sampled at edge n gives sadValid sampled at edge n+3
	latencyCheck: assert property (@(posedge clk) disable iff (reset)
		$past(inStrobe && inLast && latencyOn, 3) |-> sadValid)
		else begin
			protocolErrors++;
			$display("ERR %0t: sadValid missing 3 cycles after last pair", $time);
		end

	earlyCheck: assert property (@(posedge clk) disable iff (reset)
		(sadValid && latencyOn) |-> $past(inStrobe && inLast, 3))
		else begin
			protocolErrors++;
			$display("ERR %0t: sadValid not 3 cycles after a last pair", $time);
		end

	holdCheck: assert property (@(posedge clk) disable iff (reset) $past(hold) |-> !sadValid)
		else begin
			protocolErrors++;
			$display("ERR %0t: sadValid while hold high", $time);
		end

	overflowLowCheck: assert property (@(posedge clk) disable iff (reset)
		!overflowAllowed |-> !overflow)
		else begin
			protocolErrors++;
			$display("ERR %0t: overflow high without a dropped item", $time);
		end

	stickyCheck: assert property (@(posedge clk) disable iff (reset)
		$past(overflow) |-> overflow)
		else begin
			protocolErrors++;
			$display("ERR %0t: overflow fell before reset", $time);
		end

	initial begin
		seed = 23;
		reset = 1'b1;
		inStrobe = 1'b0;
		inLast = 1'b0;
		hold = 1'b0;
		pixelA = '0;
		pixelB = '0;
		latencyOn = 1'b1;
		overflowAllowed = 1'b0;
		modelSad = 0;
		modelMatches = 0;
		refreshHead();
		#0.5;
		resetAndCheck();

		for (int b = 0; b < blockCount; b++) sendRandomBlock(blockLen);
		for (int i = 0; i < 8; i++) sendPair(dirA[i], dirB[i], i == 7);
		for (int i = 0; i < satLen; i++) sendPair(8'd0, 8'd255, i == satLen - 1);
		waitDrain();
		latencyOn = 1'b0;

		hold = 1'b1;  // two short blocks parked in the fifo
		sendRandomBlock(2);
		sendRandomBlock(2);
		repeat (3) @(posedge clk);
		#0.5;
		hold = 1'b0;
		waitDrain();

		overflowAllowed = 1'b1;
		hold = 1'b1;
		for (int i = 0; i < 7; i++) sendPair(8'd10, 8'd3, 1'b0);
		repeat (3) @(posedge clk);
		#0.5;
		assert (overflow) else begin
			protocolErrors++;
			$display("ERR %0t: overflow low after pushes into a full fifo", $time);
		end
		resetAndCheck();

		$display("errors: value %0d, protocol %0d", valueErrors, protocolErrors);
		if (valueErrors + protocolErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
source/sadPkg.sv
source/prefixAndOr.sv
source/subCZ.sv
source/pixelDiffer.sv
source/diffFifo.sv
source/sadAccumulator.sv
source/sadUnit.sv
bench/sadUnitTb.sv

// File: Bender.yml
package:
  name: sad_unit

sources:
  - source/sadPkg.sv
  - source/prefixAndOr.sv
  - source/subCZ.sv
  - source/pixelDiffer.sv
  - source/diffFifo.sv
  - source/sadAccumulator.sv
  - source/sadUnit.sv
  - target: simulation
    files:
      - bench/sadUnitTb.sv
